// File: hw/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// register and data width
`define RV_XLEN 64

// architectural register count
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 64'h0000_0000_0000_0000

// ebreak is a single fixed encoding
`define RV_EBREAK 32'h0010_0073

`endif

// File: hw/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

  // supported subset, anything else decodes to op_illegal
  typedef enum logic [3:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_addi,
    op_add,
    op_sub,
    op_lw,
    op_sw,
    op_ebreak,
    op_illegal
  } op_e;

  // imm is already sign-extended for the format of op
  typedef struct packed {
    op_e                 op;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] imm;
  } decoded_t;

endpackage

// File: hw/rv_ifaces.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

// single-outstanding memory request channel
interface mem_if;
  logic                  valid;
  logic                  ready;
  logic [`RV_XLEN-1:0]   addr;
  logic                  write;
  logic [`RV_XLEN-1:0]   wdata;
  logic [`RV_XLEN/8-1:0] wmask;
  logic                  rsp_valid;
  logic [`RV_XLEN-1:0]   rdata;

  modport requester (
    output valid, addr, write, wdata, wmask,
    input  ready, rsp_valid, rdata
  );

  modport server (
    input  valid, addr, write, wdata, wmask,
    output ready, rsp_valid, rdata
  );
endinterface

// fetch to execute handoff, redirect flows back
interface fetch_if;
  logic                inst_valid;
  logic                inst_ready;
  logic [`RV_XLEN-1:0] inst_pc;
  logic [31:0]         inst_word;
  logic                redirect;
  logic [`RV_XLEN-1:0] redirect_pc;

  modport producer (
    output inst_valid, inst_pc, inst_word,
    input  inst_ready, redirect, redirect_pc
  );

  modport consumer (
    input  inst_valid, inst_pc, inst_word,
    output inst_ready, redirect, redirect_pc
  );
endinterface

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_unit (
  input logic       clk,
  input logic       reset,
  mem_if.requester  mem,
  fetch_if.producer fe
);
  logic                req_valid;
  logic [`RV_XLEN-1:0] req_addr;
  logic                outstanding;
  logic                drop;
  logic [`RV_XLEN-1:0] next_pc;
  logic                buf_valid;
  logic [`RV_XLEN-1:0] buf_pc;
  logic [31:0]         buf_word;
  logic                handover;
  logic                rsp_now;
  logic                can_issue;
  logic [`RV_XLEN-1:0] fetch_target;

  assign handover = buf_valid && fe.inst_ready;
  assign rsp_now  = outstanding && mem.rsp_valid;

  // one request at a time, and only into a free buffer
  assign can_issue = !req_valid && !outstanding &&
                     (!buf_valid || handover || fe.redirect);
  assign fetch_target = fe.redirect ? fe.redirect_pc : next_pc;

  assign mem.valid = req_valid;
  assign mem.addr  = req_addr;
  assign mem.write = 1'b0;
  assign mem.wdata = '0;
  assign mem.wmask = '0;

  assign fe.inst_valid = buf_valid;
  assign fe.inst_pc    = buf_pc;
  assign fe.inst_word  = buf_word;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid   <= 1'b0;
      outstanding <= 1'b0;
      drop        <= 1'b0;
      buf_valid   <= 1'b0;
      next_pc     <= `RV_RESET_PC;
    end else begin
      if (req_valid && mem.ready) begin
        req_valid   <= 1'b0;
        outstanding <= 1'b1;
      end
      if (rsp_now) begin
        outstanding <= 1'b0;
        drop        <= 1'b0;
        buf_valid   <= !drop;
      end
      if (handover)
        buf_valid <= 1'b0;
      // stale prefetch still on its way gets thrown away
      if (fe.redirect) begin
        buf_valid <= 1'b0;
        next_pc   <= fe.redirect_pc;
        if (req_valid || (outstanding && !mem.rsp_valid))
          drop <= 1'b1;
      end
      if (can_issue) begin
        req_valid <= 1'b1;
        next_pc   <= fetch_target + `RV_XLEN'(4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (can_issue)
      req_addr <= fetch_target;
    if (rsp_now) begin
      buf_pc   <= req_addr;
      // pick the 32-bit half of the memory word
      buf_word <= req_addr[2] ? mem.rdata[`RV_XLEN-1:32] : mem.rdata[31:0];
    end
  end

endmodule

// File: hw/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decoder (
  input  logic [31:0]      word,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign opcode = word[6:0];
  assign funct3 = word[14:12];
  assign funct7 = word[31:25];

  // immediates per format, all sign-extended from bit 31
  assign imm_i = {{(`RV_XLEN-12){word[31]}}, word[31:20]};
  assign imm_s = {{(`RV_XLEN-12){word[31]}}, word[31:25], word[11:7]};
  assign imm_b = {{(`RV_XLEN-13){word[31]}}, word[31], word[7], word[30:25],
                  word[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){word[31]}}, word[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){word[31]}}, word[31], word[19:12], word[20],
                  word[30:21], 1'b0};

  always_comb begin
    dec.op  = op_illegal;
    dec.rd  = word[11:7];
    dec.rs1 = word[19:15];
    dec.rs2 = word[24:20];
    dec.imm = imm_i;
    case (opcode)
      7'b0110111: begin
        dec.op  = op_lui;
        dec.imm = imm_u;
      end
      7'b0010111: begin
        dec.op  = op_auipc;
        dec.imm = imm_u;
      end
      7'b1101111: begin
        dec.op  = op_jal;
        dec.imm = imm_j;
      end
      7'b1100111: begin
        if (funct3 == 3'b000)
          dec.op = op_jalr;
      end
      7'b1100011: begin
        dec.imm = imm_b;
        if (funct3 == 3'b000)
          dec.op = op_beq;
        else if (funct3 == 3'b001)
          dec.op = op_bne;
      end
      7'b0010011: begin
        if (funct3 == 3'b000)
          dec.op = op_addi;
      end
      7'b0110011: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000)
          dec.op = op_add;
        else if (funct3 == 3'b000 && funct7 == 7'b0100000)
          dec.op = op_sub;
      end
      7'b0000011: begin
        if (funct3 == 3'b010)
          dec.op = op_lw;
      end
      7'b0100011: begin
        dec.imm = imm_s;
        if (funct3 == 3'b010)
          dec.op = op_sw;
      end
      default: begin
        // only the exact ebreak word is accepted from the system opcode
        if (word == `RV_EBREAK)
          dec.op = op_ebreak;
      end
    endcase
  end

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module exec_unit (
  input  logic                clk,
  input  logic                reset,
  fetch_if.consumer           fe,
  mem_if.requester            dmem,
  output logic                retire_valid,
  output logic [`RV_XLEN-1:0] retire_pc,
  output logic [4:0]          retire_rd,
  output logic [`RV_XLEN-1:0] retire_wdata,
  output logic                halted,
  output logic                halt_code
);
  import rv_pkg::*;

  typedef enum logic [2:0] {s_idle, s_exec, s_mem, s_wait, s_halt} state_e;

  state_e              state;
  decoded_t            dec_in;
  decoded_t            cur;
  logic [`RV_XLEN-1:0] cur_pc;
  logic [31:0]         ld_word;
  logic [`RV_XLEN-1:0] regs [`RV_NREGS];
  logic [`RV_XLEN-1:0] rs1_val, rs2_val, add_a, add_b, sum, diff;
  logic [`RV_XLEN-1:0] pc_plus4, br_target, next_pc, result;
  logic                take;
  logic                writes_rd;

  rv_decoder dec0 (.word(fe.inst_word), .dec(dec_in));

  assign fe.inst_ready = (state == s_idle);
  assign take          = fe.inst_valid && fe.inst_ready;

  // x0 reads as zero, the array entry is never written
  assign rs1_val = (cur.rs1 == 5'd0) ? '0 : regs[cur.rs1];
  assign rs2_val = (cur.rs2 == 5'd0) ? '0 : regs[cur.rs2];

  // shared adder for addi, add, auipc, jalr and load/store address
  assign add_a     = (cur.op == op_auipc) ? cur_pc : rs1_val;
  assign add_b     = (cur.op == op_add) ? rs2_val : cur.imm;
  assign sum       = add_a + add_b;
  assign diff      = rs1_val - rs2_val;
  assign pc_plus4  = cur_pc + `RV_XLEN'(4);
  assign br_target = cur_pc + cur.imm;

  always_comb begin
    case (cur.op)
      op_jal:  next_pc = br_target;
      op_jalr: next_pc = {sum[`RV_XLEN-1:1], 1'b0};
      op_beq:  next_pc = (diff == '0) ? br_target : pc_plus4;
      op_bne:  next_pc = (diff != '0) ? br_target : pc_plus4;
      default: next_pc = pc_plus4;
    endcase
  end

  always_comb begin
    writes_rd = 1'b1;
    case (cur.op)
      op_lui:                   result = cur.imm;
      op_auipc, op_addi, op_add: result = sum;
      op_sub:                   result = diff;
      op_jal, op_jalr:          result = pc_plus4;
      op_lw:                    result = {{(`RV_XLEN-32){ld_word[31]}}, ld_word};
      default: begin
        result    = '0;
        writes_rd = 1'b0;
      end
    endcase
  end

  assign fe.redirect    = (state == s_exec) && (next_pc != pc_plus4);
  assign fe.redirect_pc = next_pc;

  // word access, lane picked by address bit 2
  assign dmem.valid = (state == s_mem);
  assign dmem.addr  = sum;
  assign dmem.write = (cur.op == op_sw);
  assign dmem.wdata = {2{rs2_val[31:0]}};
  assign dmem.wmask = sum[2] ? 8'hf0 : 8'h0f;

  assign retire_valid = (state == s_exec);
  assign retire_pc    = cur_pc;
  assign retire_rd    = writes_rd ? cur.rd : 5'd0;
  assign retire_wdata = (retire_rd != 5'd0) ? result : '0;
  assign halted       = (state == s_halt);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= s_idle;
      halt_code <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (take)
            state <= (dec_in.op == op_lw || dec_in.op == op_sw) ? s_mem : s_exec;
        end
        s_mem: begin
          if (dmem.ready)
            state <= s_wait;
        end
        s_wait: begin
          if (dmem.rsp_valid)
            state <= s_exec;
        end
        s_exec: begin
          if (cur.op == op_ebreak || cur.op == op_illegal) begin
            state     <= s_halt;
            halt_code <= (cur.op == op_illegal) || (regs[10] != '0);
          end else begin
            state <= s_idle;
          end
        end
        default: state <= s_halt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      cur    <= dec_in;
      cur_pc <= fe.inst_pc;
    end
    if (state == s_wait && dmem.rsp_valid)
      ld_word <= sum[2] ? dmem.rdata[`RV_XLEN-1:32] : dmem.rdata[31:0];
    if (retire_valid && retire_rd != 5'd0)
      regs[retire_rd] <= result;
  end

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input logic      clk,
  input logic      reset,
  mem_if.server    a,
  mem_if.server    b,
  mem_if.requester mem
);
  logic busy;
  logic owner_b;
  logic locked;
  logic locked_b;
  logic grant_b;

  // a stalled request keeps its grant so the port stays stable
  assign grant_b = locked ? locked_b : b.valid;

  assign mem.valid = !busy && (grant_b ? b.valid : a.valid);
  assign mem.addr  = grant_b ? b.addr : a.addr;
  assign mem.write = grant_b ? b.write : a.write;
  assign mem.wdata = grant_b ? b.wdata : a.wdata;
  assign mem.wmask = grant_b ? b.wmask : a.wmask;

  assign a.ready = !busy && !grant_b && mem.ready;
  assign b.ready = !busy && grant_b && mem.ready;

  // response only goes to whoever owns the transfer
  assign a.rsp_valid = busy && !owner_b && mem.rsp_valid;
  assign b.rsp_valid = busy && owner_b && mem.rsp_valid;
  assign a.rdata     = mem.rdata;
  assign b.rdata     = mem.rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      owner_b  <= 1'b0;
      locked   <= 1'b0;
      locked_b <= 1'b0;
    end else if (mem.valid && mem.ready) begin
      busy    <= 1'b1;
      owner_b <= grant_b;
      locked  <= 1'b0;
    end else begin
      if (mem.rsp_valid)
        busy <= 1'b0;
      locked   <= mem.valid;
      locked_b <= grant_b;
    end
  end

endmodule

// File: hw/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_top (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  mem_req_valid,
  input  logic                  mem_req_ready,
  output logic [`RV_XLEN-1:0]   mem_req_addr,
  output logic                  mem_req_write,
  output logic [`RV_XLEN-1:0]   mem_req_wdata,
  output logic [`RV_XLEN/8-1:0] mem_req_wmask,
  input  logic                  mem_rsp_valid,
  input  logic [`RV_XLEN-1:0]   mem_rsp_rdata,
  output logic                  retire_valid,
  output logic [`RV_XLEN-1:0]   retire_pc,
  output logic [4:0]            retire_rd,
  output logic [`RV_XLEN-1:0]   retire_wdata,
  output logic                  halted,
  output logic                  halt_code
);
  mem_if   fetch_mem ();
  mem_if   data_mem ();
  mem_if   ext_mem ();
  fetch_if fe_bus ();

  fetch_unit fetch0 (
    .clk   (clk),
    .reset (reset),
    .mem   (fetch_mem),
    .fe    (fe_bus)
  );

  exec_unit exec0 (
    .clk          (clk),
    .reset        (reset),
    .fe           (fe_bus),
    .dmem         (data_mem),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wdata (retire_wdata),
    .halted       (halted),
    .halt_code    (halt_code)
  );

  // data side wins ties
  mem_arbiter arb0 (
    .clk   (clk),
    .reset (reset),
    .a     (fetch_mem),
    .b     (data_mem),
    .mem   (ext_mem)
  );

  assign mem_req_valid     = ext_mem.valid;
  assign mem_req_addr      = ext_mem.addr;
  assign mem_req_write     = ext_mem.write;
  assign mem_req_wdata     = ext_mem.wdata;
  assign mem_req_wmask     = ext_mem.wmask;
  assign ext_mem.ready     = mem_req_ready;
  assign ext_mem.rsp_valid = mem_rsp_valid;
  assign ext_mem.rdata     = mem_rsp_rdata;

endmodule

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;

  localparam int opc_lui    = 'h37;
  localparam int opc_auipc  = 'h17;
  localparam int opc_jalr   = 'h67;
  localparam int opc_op_imm = 'h13;
  localparam int opc_load   = 'h03;
  // budget covers 60 retires against 38 in the program
  localparam int max_retires    = 60;
  localparam int worst_cycles   = 12;
  // rounded up to 1000 for reset and the tail after halt
  localparam int timeout_cycles = max_retires * worst_cycles + 280;

  logic        clk = 1'b0;
  logic        reset;
  logic        mem_req_valid;
  logic        mem_req_ready;
  logic [63:0] mem_req_addr;
  logic        mem_req_write;
  logic [63:0] mem_req_wdata;
  logic [7:0]  mem_req_wmask;
  logic        mem_rsp_valid;
  logic [63:0] mem_rsp_rdata;
  logic        retire_valid;
  logic [63:0] retire_pc;
  logic [4:0]  retire_rd;
  logic [63:0] retire_wdata;
  logic        halted;
  logic        halt_code;

  // memory model and reference state
  logic [63:0] mem_model [logic [63:0]];
  logic [63:0] iss_mem [logic [63:0]];
  logic [63:0] iss_regs [32];
  logic [63:0] iss_pc = `RV_RESET_PC;
  logic        iss_done = 1'b0;
  logic        iss_illegal = 1'b0;
  logic [63:0] prog_addr = `RV_RESET_PC;
  logic [31:0] rng_state = 32'hc9e4_5c27;
  int          retire_count = 0;
  int          cycle_count = 0;

  logic        rsp_pending = 1'b0;
  logic [1:0]  rsp_wait;
  logic [63:0] req_addr_q;
  logic        req_write_q;
  logic [63:0] req_wdata_q;
  logic [7:0]  req_wmask_q;

  rv_core_top dut0 (.*);

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected)
      abort_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one instruction encoder per format
  function automatic logic [31:0] itype_word(input int opc, input int f3, input int rd,
                                             input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] rtype_word(input int f7, input int rd, input int rs1,
                                             input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] stype_word(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] btype_word(input int f3, input int rs1, input int rs2,
                                             input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] utype_word(input int opc, input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] jtype_word(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  // places one instruction in both memories at the running address
  task automatic emit(input logic [31:0] w);
    logic [63:0] word;
    word = mem_model.exists(prog_addr >> 3) ? mem_model[prog_addr >> 3] : 64'd0;
    if (prog_addr[2])
      word[63:32] = w;
    else
      word[31:0] = w;
    mem_model[prog_addr >> 3] = word;
    iss_mem[prog_addr >> 3]   = word;
    prog_addr = prog_addr + 64'd4;
  endtask

  task automatic put_data(input logic [63:0] addr, input logic [63:0] word);
    mem_model[addr >> 3] = word;
    iss_mem[addr >> 3]   = word;
  endtask

  task automatic load_program();
    emit(utype_word(opc_lui, 1, 'h12345));
    emit(itype_word(opc_op_imm, 0, 2, 0, -5));
    emit(rtype_word(0, 3, 1, 2));
    emit(rtype_word(32, 4, 2, 1));
    emit(utype_word(opc_auipc, 5, 1));
    // x0 write and x0 read back
    emit(itype_word(opc_op_imm, 0, 0, 1, 7));
    emit(rtype_word(0, 6, 0, 3));
    emit(utype_word(opc_lui, 7, 'h80000));
    emit(btype_word(0, 2, 2, 8));
    emit(itype_word(opc_op_imm, 0, 8, 0, 99));
    emit(btype_word(1, 2, 2, 8));
    emit(btype_word(1, 1, 2, 12));
    emit(itype_word(opc_op_imm, 0, 8, 0, 1));
    emit(itype_word(opc_op_imm, 0, 8, 0, 2));
    emit(btype_word(0, 1, 2, -16));
    emit(jtype_word(9, 12));
    emit(itype_word(opc_op_imm, 0, 8, 0, 3));
    emit(itype_word(opc_op_imm, 0, 8, 0, 4));
    // loads from both halves and a store with reload
    emit(itype_word(opc_op_imm, 0, 11, 0, 'h200));
    emit(itype_word(opc_load, 2, 12, 11, 0));
    emit(itype_word(opc_load, 2, 13, 11, 4));
    emit(itype_word(opc_load, 2, 14, 11, 8));
    emit(itype_word(opc_load, 2, 15, 11, 12));
    emit(stype_word(4, 11, 16));
    emit(stype_word(3, 11, 20));
    emit(itype_word(opc_load, 2, 16, 11, 16));
    emit(itype_word(opc_load, 2, 17, 11, 20));
    emit(rtype_word(32, 18, 17, 3));
    // jalr with an odd offset clears the low bit
    emit(itype_word(opc_op_imm, 0, 19, 0, 'h80));
    emit(itype_word(opc_jalr, 0, 20, 19, 1));
    emit(itype_word(opc_op_imm, 0, 8, 0, 5));
    emit(itype_word(opc_op_imm, 0, 8, 0, 6));
    emit(rtype_word(0, 21, 12, 13));
    emit(jtype_word(22, 8));
    emit(itype_word(opc_op_imm, 0, 8, 0, 7));
    emit(stype_word(1, 11, 24));
    emit(itype_word(opc_load, 2, 23, 11, 24));
    // a0 ends up nonzero for the halt code
    emit(rtype_word(32, 10, 23, 3));
    // short loop on a backward bne
    emit(itype_word(opc_op_imm, 0, 24, 0, 3));
    emit(itype_word(opc_op_imm, 0, 24, 24, -1));
    emit(btype_word(1, 24, 0, -4));
    emit(`RV_EBREAK);
    put_data(64'h200, 64'h8765_4321_1234_5678);
    put_data(64'h208, 64'h0bad_cafe_fedc_ba98);
    put_data(64'h210, 64'h5555_5555_aaaa_aaaa);
    put_data(64'h218, 64'h0123_4567_89ab_cdef);
  endtask

  // reference ISS stepping one instruction per call
  function automatic void iss_step(output logic [63:0] pc_o, output logic [4:0] rd_o,
                                   output logic [63:0] wdata_o, output logic [63:0] next_o);
    logic [63:0] word64;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [63:0] addr;
    logic [31:0] w;
    logic [31:0] half;
    logic        wr;
    word64 = iss_mem.exists(iss_pc >> 3) ? iss_mem[iss_pc >> 3] : 64'd0;
    w      = iss_pc[2] ? word64[63:32] : word64[31:0];
    a      = iss_regs[w[19:15]];
    b      = iss_regs[w[24:20]];
    res    = 64'd0;
    wr     = 1'b1;
    next_o = iss_pc + 64'd4;
    case (w[6:0])
      7'b0110111: res = {{32{w[31]}}, w[31:12], 12'b0};
      7'b0010111: res = iss_pc + {{32{w[31]}}, w[31:12], 12'b0};
      7'b1101111: begin
        res    = iss_pc + 64'd4;
        next_o = iss_pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100111: begin
        res    = iss_pc + 64'd4;
        next_o = (a + {{52{w[31]}}, w[31:20]}) & ~64'd1;
      end
      7'b1100011: begin
        wr = 1'b0;
        if ((w[12] == 1'b0) == (a == b))
          next_o = iss_pc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      7'b0010011: res = a + {{52{w[31]}}, w[31:20]};
      7'b0110011: res = w[30] ? a - b : a + b;
      7'b0000011: begin
        addr   = a + {{52{w[31]}}, w[31:20]};
        word64 = iss_mem.exists(addr >> 3) ? iss_mem[addr >> 3] : 64'd0;
        half   = addr[2] ? word64[63:32] : word64[31:0];
        res    = {{32{half[31]}}, half};
      end
      7'b0100011: begin
        wr     = 1'b0;
        addr   = a + {{52{w[31]}}, w[31:25], w[11:7]};
        word64 = iss_mem.exists(addr >> 3) ? iss_mem[addr >> 3] : 64'd0;
        if (addr[2])
          word64[63:32] = b[31:0];
        else
          word64[31:0] = b[31:0];
        iss_mem[addr >> 3] = word64;
      end
      default: begin
        wr          = 1'b0;
        iss_done    = 1'b1;
        iss_illegal = (w != `RV_EBREAK);
      end
    endcase
    if (wr && w[11:7] != 5'd0)
      iss_regs[w[11:7]] = res;
    pc_o    = iss_pc;
    rd_o    = wr ? w[11:7] : 5'd0;
    wdata_o = (rd_o != 5'd0) ? res : 64'd0;
  endfunction

  // memory model with random ready and response delay
  always @(negedge clk) begin
    logic [63:0] word;
    mem_rsp_valid = 1'b0;
    if (rsp_pending) begin
      if (rsp_wait == 2'd0) begin
        word = mem_model.exists(req_addr_q >> 3) ? mem_model[req_addr_q >> 3] : 64'd0;
        if (req_write_q) begin
          for (int i = 0; i < 8; i++) begin
            if (req_wmask_q[i])
              word[8*i +: 8] = req_wdata_q[8*i +: 8];
          end
          mem_model[req_addr_q >> 3] = word;
        end
        mem_rsp_rdata = word;
        mem_rsp_valid = 1'b1;
        rsp_pending   = 1'b0;
      end else begin
        rsp_wait = rsp_wait - 2'd1;
      end
    end
    rng_state     = xorshift(rng_state);
    mem_req_ready = (rng_state[1:0] != 2'b00);
    if (!reset && mem_req_valid && mem_req_ready) begin
      if (rsp_pending || mem_rsp_valid)
        abort_run("memory request accepted while another one is outstanding");
      req_addr_q  = mem_req_addr;
      req_write_q = mem_req_write;
      req_wdata_q = mem_req_wdata;
      req_wmask_q = mem_req_wmask;
      rng_state   = xorshift(rng_state);
      // delay of 1 to 4 cycles
      rsp_wait    = rng_state[1:0];
      rsp_pending = 1'b1;
    end
  end

  // retire compare against the ISS
  always @(negedge clk) begin
    logic [63:0] exp_pc;
    logic [63:0] exp_wdata;
    logic [63:0] exp_next;
    logic [4:0]  exp_rd;
    if (!reset && retire_valid === 1'b1) begin
      if (iss_done)
        abort_run("an instruction retired after the core halted");
      iss_step(exp_pc, exp_rd, exp_wdata, exp_next);
      check($sformatf("retire %0d pc", retire_count), exp_pc, retire_pc);
      check($sformatf("retire %0d rd", retire_count), 64'(exp_rd), 64'(retire_rd));
      check($sformatf("retire %0d wdata", retire_count), exp_wdata, retire_wdata);
      iss_pc       = exp_next;
      retire_count = retire_count + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles)
      abort_run($sformatf("timeout, core not halted after %0d cycles", timeout_cycles));
  end

  initial begin
    reset         = 1'b1;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_rdata = 64'd0;
    for (int r = 0; r < 32; r++)
      iss_regs[r] = 64'd0;
    load_program();
    repeat (5) @(negedge clk);
    check("mem_req_valid in reset", 64'd0, 64'(mem_req_valid));
    check("retire_valid in reset", 64'd0, 64'(retire_valid));
    check("halted in reset", 64'd0, 64'(halted));
    reset = 1'b0;
    @(negedge clk);
    check("first fetch valid", 64'd1, 64'(mem_req_valid));
    check("first fetch addr", `RV_RESET_PC, mem_req_addr);
    while (!halted)
      @(negedge clk);
    check("ebreak retired before halt", 64'd1, 64'(iss_done));
    check("halt code", 64'(iss_illegal || iss_regs[10] != 64'd0), 64'(halt_code));
    repeat (10) begin
      @(negedge clk);
      check("halted stays high", 64'd1, 64'(halted));
    end
    foreach (iss_mem[k])
      check($sformatf("memory word %h", k << 3), iss_mem[k], mem_model[k]);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_ifaces.sv
hw/fetch_unit.sv
hw/rv_decoder.sv
hw/exec_unit.sv
hw/mem_arbiter.sv
hw/rv_core_top.sv
testbench/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_rv_core
FILELIST  ?= sources.f

.PHONY: sim clean

# pass or fail is taken from the simulation output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	out="$$(./obj_dir/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
